// File: common/core_pkg.sv
/* Integer execution pipe types
   Rename IDs, done tags, bypass bus size and the op, immediate and multiplier state encodings */
package core_pkg;

  typedef logic [5:0] rnid_t; // Physical register
  typedef logic [4:0] tag_t;

  localparam int FWD_PORTS = 2;

  // ----------------------------------------------------------
  // Decoded operation
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    OP_NONE  = 4'd0,
    OP_ADD   = 4'd1,
    OP_SUB   = 4'd2,
    OP_XOR   = 4'd3,
    OP_OR    = 4'd4,
    OP_AND   = 4'd5,
    OP_SLL   = 4'd6,
    OP_SRL   = 4'd7,
    OP_SRA   = 4'd8,
    OP_SLT   = 4'd9,
    OP_SLTU  = 4'd10,
    OP_LUI   = 4'd11,
    OP_AUIPC = 4'd12,
    OP_MUL   = 4'd13
  } op_t;

  typedef enum logic [1:0] {
    IMM_NONE = 2'd0,
    IMM_I    = 2'd1, // Sign-extended inst[31:20]
    IMM_SH   = 2'd2, // Shift amount
    IMM_U    = 2'd3
  } imm_t;

  typedef enum logic {
    IDLE = 1'b0,
    RUN  = 1'b1
  } mul_state_t;

endpackage

// File: common/isa_pkg.sv
/* RISC-V RV32I base definitions
   Data, address and instruction words plus the opcode and funct fields the decoder reads */
package isa_pkg;

  localparam int XLEN_W  = 32;
  localparam int SHAMT_W = 5;

  typedef logic [XLEN_W-1:0] xlen_t;
  typedef logic [XLEN_W-1:0] vaddr_t;
  typedef logic [31:0]       inst_t;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // ----------------------------------------------------------
  // Major opcodes
  // ----------------------------------------------------------
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  localparam funct7_t F7_BASE   = 7'b0000000;
  localparam funct7_t F7_ALT    = 7'b0100000; // SUB / SRA
  localparam funct7_t F7_MULDIV = 7'b0000001; // M extension

endpackage

// File: hw/alu_decode.sv
/* EX0 instruction decoder
   Maps opcode, funct3 and funct7 onto the ALU operation and immediate kind */
`timescale 1ns/10ps

module alu_decode (
  input  isa_pkg::inst_t  i_inst,
  output core_pkg::op_t   o_op,
  output core_pkg::imm_t  o_imm
);

  isa_pkg::opcode_t w_opcode;
  isa_pkg::funct3_t w_funct3;
  isa_pkg::funct7_t w_funct7;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign w_funct7 = i_inst[31:25];

  always_comb begin
    o_op  = core_pkg::OP_NONE;
    o_imm = core_pkg::IMM_NONE;
    case (w_opcode)
      isa_pkg::OPC_OP: begin
        if (w_funct7 == isa_pkg::F7_BASE) begin
          case (w_funct3)
            3'b000: o_op = core_pkg::OP_ADD;
            3'b001: o_op = core_pkg::OP_SLL;
            3'b010: o_op = core_pkg::OP_SLT;
            3'b011: o_op = core_pkg::OP_SLTU;
            3'b100: o_op = core_pkg::OP_XOR;
            3'b101: o_op = core_pkg::OP_SRL;
            3'b110: o_op = core_pkg::OP_OR;
            3'b111: o_op = core_pkg::OP_AND;
          endcase
        end else if (w_funct7 == isa_pkg::F7_ALT) begin
          if (w_funct3 == 3'b000) o_op = core_pkg::OP_SUB;
          if (w_funct3 == 3'b101) o_op = core_pkg::OP_SRA;
        end else if (w_funct7 == isa_pkg::F7_MULDIV && w_funct3 == 3'b000) begin
          o_op = core_pkg::OP_MUL; // MULH variants not supported
        end
      end
      isa_pkg::OPC_OP_IMM: begin
        o_imm = core_pkg::IMM_I;
        case (w_funct3)
          3'b000: o_op = core_pkg::OP_ADD;
          3'b010: o_op = core_pkg::OP_SLT;
          3'b011: o_op = core_pkg::OP_SLTU;
          3'b100: o_op = core_pkg::OP_XOR;
          3'b110: o_op = core_pkg::OP_OR;
          3'b111: o_op = core_pkg::OP_AND;
          3'b001: if (w_funct7 == isa_pkg::F7_BASE) o_op = core_pkg::OP_SLL;
          3'b101: begin
            if (w_funct7 == isa_pkg::F7_BASE) o_op = core_pkg::OP_SRL;
            else if (w_funct7 == isa_pkg::F7_ALT) o_op = core_pkg::OP_SRA;
          end
        endcase
        if (w_funct3 == 3'b001 || w_funct3 == 3'b101) o_imm = core_pkg::IMM_SH;
      end
      isa_pkg::OPC_LUI: begin
        o_op  = core_pkg::OP_LUI;
        o_imm = core_pkg::IMM_U;
      end
      isa_pkg::OPC_AUIPC: begin
        o_op  = core_pkg::OP_AUIPC;
        o_imm = core_pkg::IMM_U;
      end
      default: o_op = core_pkg::OP_NONE;
    endcase
    if (o_op == core_pkg::OP_NONE) o_imm = core_pkg::IMM_NONE; // Illegal encodings write zero
  end

endmodule

// File: hw/alu_execute.sv
/* EX2 integer ALU
   Add, sub, logic, shifts, compares and U-type results, registered into EX3 */
`timescale 1ns/10ps

module alu_execute (
  input  logic            i_clk,
  input  logic            i_reset_n,
  input  core_pkg::op_t   i_op,
  input  isa_pkg::xlen_t  i_rs1,
  input  isa_pkg::xlen_t  i_rs2,
  input  isa_pkg::inst_t  i_inst,
  input  isa_pkg::vaddr_t i_pc,
  output isa_pkg::xlen_t  o_result
);

  logic [isa_pkg::SHAMT_W-1:0] w_shamt;
  isa_pkg::xlen_t              w_uimm;
  isa_pkg::xlen_t              w_result;

  assign w_shamt = i_rs2[isa_pkg::SHAMT_W-1:0];
  assign w_uimm  = {i_inst[31:12], 12'h000};

  always_comb begin
    case (i_op)
      core_pkg::OP_ADD:   w_result = i_rs1 + i_rs2;
      core_pkg::OP_SUB:   w_result = i_rs1 - i_rs2;
      core_pkg::OP_XOR:   w_result = i_rs1 ^ i_rs2;
      core_pkg::OP_OR:    w_result = i_rs1 | i_rs2;
      core_pkg::OP_AND:   w_result = i_rs1 & i_rs2;
      core_pkg::OP_SLL:   w_result = i_rs1 << w_shamt;
      core_pkg::OP_SRL:   w_result = i_rs1 >> w_shamt;
      core_pkg::OP_SRA:   w_result = $signed(i_rs1) >>> w_shamt;
      core_pkg::OP_SLT:
        w_result = {{(isa_pkg::XLEN_W-1){1'b0}}, $signed(i_rs1) < $signed(i_rs2)};
      core_pkg::OP_SLTU:
        w_result = {{(isa_pkg::XLEN_W-1){1'b0}}, i_rs1 < i_rs2};
      core_pkg::OP_LUI:   w_result = w_uimm;
      core_pkg::OP_AUIPC: w_result = i_pc + w_uimm;
      default:            w_result = '0; // OP_NONE, MUL handled elsewhere
    endcase
  end

  // EX3 result register
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_result <= '0;
    end else begin
      o_result <= w_result;
    end
  end

endmodule

// File: hw/alu_pipe.sv
/* Integer ALU execution pipe
   EX0 decode, EX1 register read, EX2 compute or multiply start, EX3 writeback and done */
`timescale 1ns/10ps

module alu_pipe #(
  parameter int MUL_UNROLL = 8,
  parameter int FWD_PORTS  = core_pkg::FWD_PORTS
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  input  logic                 i_issue_valid,
  input  isa_pkg::inst_t       i_issue_inst,
  input  isa_pkg::vaddr_t      i_issue_pc,
  input  core_pkg::tag_t       i_issue_tag,
  input  core_pkg::rnid_t      i_rs1_rnid,
  input  core_pkg::rnid_t      i_rs2_rnid,
  input  logic                 i_rs1_used,
  input  logic                 i_rs2_used,
  input  core_pkg::rnid_t      i_rd_rnid,
  output logic                 o_rs1_rd_valid,
  output core_pkg::rnid_t      o_rs1_rd_rnid,
  input  isa_pkg::xlen_t       i_rs1_rd_data,
  output logic                 o_rs2_rd_valid,
  output core_pkg::rnid_t      o_rs2_rd_rnid,
  input  isa_pkg::xlen_t       i_rs2_rd_data,
  input  logic [FWD_PORTS-1:0] i_fwd_valid,
  input  core_pkg::rnid_t      i_fwd_rnid [FWD_PORTS],
  input  isa_pkg::xlen_t       i_fwd_data [FWD_PORTS],
  output logic                 o_stall,
  output logic                 o_wb_valid,
  output core_pkg::rnid_t      o_wb_rnid,
  output isa_pkg::xlen_t       o_wb_data,
  output logic                 o_done_valid,
  output core_pkg::tag_t       o_done_tag
);

  core_pkg::op_t   w_ex0_op;
  core_pkg::imm_t  w_ex0_imm;

  logic            r_ex1_valid, r_ex2_valid, r_ex3_valid;
  core_pkg::tag_t  r_ex1_tag, r_ex2_tag, r_ex3_tag;
  core_pkg::rnid_t r_ex1_rd, r_ex2_rd, r_ex3_rd;
  isa_pkg::inst_t  r_ex1_inst, r_ex2_inst;
  isa_pkg::vaddr_t r_ex1_pc, r_ex2_pc;
  core_pkg::op_t   r_ex1_op, r_ex2_op;
  core_pkg::imm_t  r_ex1_imm;
  core_pkg::rnid_t r_ex1_rs1_rnid, r_ex1_rs2_rnid, r_ex2_rs1_rnid, r_ex2_rs2_rnid;
  logic            r_ex1_rs1_used, r_ex1_rs2_used;

  isa_pkg::xlen_t  w_ex2_rs1, w_ex2_rs2, w_ex3_result;
  logic            w_ex1_mul, w_ex2_mul;
  logic            w_mul_busy, w_mul_valid;
  isa_pkg::xlen_t  w_mul_res;
  core_pkg::rnid_t w_mul_rnid;
  core_pkg::tag_t  w_mul_tag;

  // ----------------------------------------------------------
  // EX0
  // ----------------------------------------------------------
  alu_decode u_alu_decode (
    .i_inst (i_issue_inst),
    .o_op   (w_ex0_op),
    .o_imm  (w_ex0_imm)
  );

  // Stage valids, flush kills all of them
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue_valid & !i_flush;
      r_ex2_valid <= r_ex1_valid & !i_flush;
      r_ex3_valid <= r_ex2_valid & !w_ex2_mul & !i_flush; // MUL leaves via the multiplier
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_tag      <= i_issue_tag;
    r_ex1_rd       <= i_rd_rnid;
    r_ex1_inst     <= i_issue_inst;
    r_ex1_pc       <= i_issue_pc;
    r_ex1_op       <= w_ex0_op;
    r_ex1_imm      <= w_ex0_imm;
    r_ex1_rs1_rnid <= i_rs1_rnid;
    r_ex1_rs2_rnid <= i_rs2_rnid;
    r_ex1_rs1_used <= i_rs1_used;
    r_ex1_rs2_used <= i_rs2_used;
    r_ex2_tag      <= r_ex1_tag;
    r_ex2_rd       <= r_ex1_rd;
    r_ex2_inst     <= r_ex1_inst;
    r_ex2_pc       <= r_ex1_pc;
    r_ex2_op       <= r_ex1_op;
    r_ex2_rs1_rnid <= r_ex1_rs1_rnid;
    r_ex2_rs2_rnid <= r_ex1_rs2_rnid;
    r_ex3_tag      <= r_ex2_tag;
    r_ex3_rd       <= r_ex2_rd;
  end

  // ----------------------------------------------------------
  // EX1 / EX2 operands and compute
  // ----------------------------------------------------------
  operand_fwd #(
    .N_FWD (FWD_PORTS)
  ) u_operand_fwd (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex1_valid    (r_ex1_valid),
    .i_rs1_rnid     (r_ex1_rs1_rnid),
    .i_rs2_rnid     (r_ex1_rs2_rnid),
    .i_rs1_used     (r_ex1_rs1_used),
    .i_rs2_used     (r_ex1_rs2_used),
    .i_ex1_inst     (r_ex1_inst),
    .i_ex1_imm      (r_ex1_imm),
    .o_rs1_rd_valid (o_rs1_rd_valid),
    .o_rs1_rd_rnid  (o_rs1_rd_rnid),
    .i_rs1_rd_data  (i_rs1_rd_data),
    .o_rs2_rd_valid (o_rs2_rd_valid),
    .o_rs2_rd_rnid  (o_rs2_rd_rnid),
    .i_rs2_rd_data  (i_rs2_rd_data),
    .i_fwd_valid    (i_fwd_valid),
    .i_fwd_rnid     (i_fwd_rnid),
    .i_fwd_data     (i_fwd_data),
    .i_ex2_rs1_rnid (r_ex2_rs1_rnid),
    .i_ex2_rs2_rnid (r_ex2_rs2_rnid),
    .o_ex2_rs1      (w_ex2_rs1),
    .o_ex2_rs2      (w_ex2_rs2)
  );

  alu_execute u_alu_execute (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_op      (r_ex2_op),
    .i_rs1     (w_ex2_rs1),
    .i_rs2     (w_ex2_rs2),
    .i_inst    (r_ex2_inst),
    .i_pc      (r_ex2_pc),
    .o_result  (w_ex3_result)
  );

  assign w_ex1_mul = r_ex1_valid & (r_ex1_op == core_pkg::OP_MUL);
  assign w_ex2_mul = r_ex2_valid & (r_ex2_op == core_pkg::OP_MUL);

  mul_unit #(
    .MUL_UNROLL (MUL_UNROLL)
  ) u_mul_unit (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_flush     (i_flush),
    .i_start     (w_ex2_mul),
    .i_rs1       (w_ex2_rs1),
    .i_rs2       (w_ex2_rs2),
    .i_rd_rnid   (r_ex2_rd),
    .i_tag       (r_ex2_tag),
    .o_busy      (w_mul_busy),
    .o_res_valid (w_mul_valid),
    .o_res       (w_mul_res),
    .o_res_rnid  (w_mul_rnid),
    .o_res_tag   (w_mul_tag)
  );

  // Hold issue from MUL decode until its result
  assign o_stall = w_ex1_mul | w_ex2_mul | w_mul_busy;

  // ----------------------------------------------------------
  // EX3 writeback and done
  // ----------------------------------------------------------
  result_arbiter u_result_arbiter (
    .i_alu_valid  (r_ex3_valid),
    .i_alu_rnid   (r_ex3_rd),
    .i_alu_data   (w_ex3_result),
    .i_alu_tag    (r_ex3_tag),
    .i_mul_valid  (w_mul_valid),
    .i_mul_rnid   (w_mul_rnid),
    .i_mul_data   (w_mul_res),
    .i_mul_tag    (w_mul_tag),
    .o_wb_valid   (o_wb_valid),
    .o_wb_rnid    (o_wb_rnid),
    .o_wb_data    (o_wb_data),
    .o_done_valid (o_done_valid),
    .o_done_tag   (o_done_tag)
  );

  a_issue_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |-> !o_stall)
    else $error("instruction issued while the pipe is stalled");

endmodule

// File: hw/operand_fwd.sv
/* EX1/EX2 operand path
   Register reads and bypass match in EX1, immediate insert, second bypass check in EX2 */
`timescale 1ns/10ps

module operand_fwd #(
  parameter int N_FWD = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_ex1_valid,
  input  core_pkg::rnid_t       i_rs1_rnid,
  input  core_pkg::rnid_t       i_rs2_rnid,
  input  logic                  i_rs1_used,
  input  logic                  i_rs2_used,
  input  isa_pkg::inst_t        i_ex1_inst,
  input  core_pkg::imm_t        i_ex1_imm,
  output logic                  o_rs1_rd_valid,
  output core_pkg::rnid_t       o_rs1_rd_rnid,
  input  isa_pkg::xlen_t        i_rs1_rd_data,
  output logic                  o_rs2_rd_valid,
  output core_pkg::rnid_t       o_rs2_rd_rnid,
  input  isa_pkg::xlen_t        i_rs2_rd_data,
  input  logic [N_FWD-1:0]      i_fwd_valid,
  input  core_pkg::rnid_t       i_fwd_rnid [N_FWD],
  input  isa_pkg::xlen_t        i_fwd_data [N_FWD],
  input  core_pkg::rnid_t       i_ex2_rs1_rnid,
  input  core_pkg::rnid_t       i_ex2_rs2_rnid,
  output isa_pkg::xlen_t        o_ex2_rs1,
  output isa_pkg::xlen_t        o_ex2_rs2
);

  logic [N_FWD-1:0] w_ex1_rs1_hit, w_ex1_rs2_hit;
  logic [N_FWD-1:0] w_ex2_rs1_hit, w_ex2_rs2_hit;
  isa_pkg::xlen_t   w_ex1_rs1_fwd, w_ex1_rs2_fwd;
  isa_pkg::xlen_t   w_ex2_rs1_fwd, w_ex2_rs2_fwd;
  isa_pkg::xlen_t   w_ex1_rs1, w_ex1_rs2;
  isa_pkg::xlen_t   r_ex2_rs1, r_ex2_rs2;
  logic             w_ex1_rs2_reg;
  logic             r_ex2_rs1_byp, r_ex2_rs2_byp;

  // Slot hit vector; x0 never matches
  function automatic logic [N_FWD-1:0] slot_hit(input core_pkg::rnid_t rnid);
    logic [N_FWD-1:0] hit;
    for (int i = 0; i < N_FWD; i++) begin
      hit[i] = i_fwd_valid[i] & (i_fwd_rnid[i] == rnid) & (rnid != '0);
    end
    return hit;
  endfunction

  function automatic isa_pkg::xlen_t slot_data(input logic [N_FWD-1:0] hit);
    isa_pkg::xlen_t data;
    data = '0;
    for (int i = 0; i < N_FWD; i++) begin
      data = data | ({isa_pkg::XLEN_W{hit[i]}} & i_fwd_data[i]);
    end
    return data;
  endfunction

  assign o_rs1_rd_valid = i_ex1_valid & i_rs1_used;
  assign o_rs1_rd_rnid  = i_rs1_rnid;
  assign o_rs2_rd_valid = i_ex1_valid & i_rs2_used;
  assign o_rs2_rd_rnid  = i_rs2_rnid;

  assign w_ex1_rs2_reg = i_rs2_used & (i_ex1_imm == core_pkg::IMM_NONE);

  always_comb begin
    w_ex1_rs1_hit = slot_hit(i_rs1_rnid) & {N_FWD{i_rs1_used}};
    w_ex1_rs2_hit = slot_hit(i_rs2_rnid) & {N_FWD{w_ex1_rs2_reg}};
    w_ex2_rs1_hit = slot_hit(i_ex2_rs1_rnid) & {N_FWD{r_ex2_rs1_byp}};
    w_ex2_rs2_hit = slot_hit(i_ex2_rs2_rnid) & {N_FWD{r_ex2_rs2_byp}};
    w_ex1_rs1_fwd = slot_data(w_ex1_rs1_hit);
    w_ex1_rs2_fwd = slot_data(w_ex1_rs2_hit);
    w_ex2_rs1_fwd = slot_data(w_ex2_rs1_hit);
    w_ex2_rs2_fwd = slot_data(w_ex2_rs2_hit);
  end

  // ----------------------------------------------------------
  // EX1 selection
  // ----------------------------------------------------------
  assign w_ex1_rs1 = |w_ex1_rs1_hit ? w_ex1_rs1_fwd : i_rs1_rd_data;

  always_comb begin
    case (i_ex1_imm)
      core_pkg::IMM_I:
        w_ex1_rs2 = {{(isa_pkg::XLEN_W-12){i_ex1_inst[31]}}, i_ex1_inst[31:20]};
      core_pkg::IMM_SH:
        w_ex1_rs2 = {{(isa_pkg::XLEN_W-isa_pkg::SHAMT_W){1'b0}},
                     i_ex1_inst[20 +: isa_pkg::SHAMT_W]};
      default:
        w_ex1_rs2 = |w_ex1_rs2_hit ? w_ex1_rs2_fwd : i_rs2_rd_data;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_rs1_byp <= 1'b0;
      r_ex2_rs2_byp <= 1'b0;
    end else begin
      r_ex2_rs1_byp <= i_rs1_used;
      r_ex2_rs2_byp <= w_ex1_rs2_reg; // Immediates are never overridden
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_rs1 <= w_ex1_rs1;
    r_ex2_rs2 <= w_ex1_rs2;
  end

  // EX2 late bypass wins over the EX1 value
  assign o_ex2_rs1 = |w_ex2_rs1_hit ? w_ex2_rs1_fwd : r_ex2_rs1;
  assign o_ex2_rs2 = |w_ex2_rs2_hit ? w_ex2_rs2_fwd : r_ex2_rs2;

  a_fwd_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex1_valid |-> $onehot0(w_ex1_rs1_hit) && $onehot0(w_ex1_rs2_hit))
    else $error("more than one bypass slot matches an EX1 source");

endmodule

// File: hw/result_arbiter.sv
/* Writeback and done port arbiter, multiplier result first */
`timescale 1ns/10ps

module result_arbiter (
  input  logic            i_alu_valid,
  input  core_pkg::rnid_t i_alu_rnid,
  input  isa_pkg::xlen_t  i_alu_data,
  input  core_pkg::tag_t  i_alu_tag,
  input  logic            i_mul_valid,
  input  core_pkg::rnid_t i_mul_rnid,
  input  isa_pkg::xlen_t  i_mul_data,
  input  core_pkg::tag_t  i_mul_tag,
  output logic            o_wb_valid,
  output core_pkg::rnid_t o_wb_rnid,
  output isa_pkg::xlen_t  o_wb_data,
  output logic            o_done_valid,
  output core_pkg::tag_t  o_done_tag
);

  always_comb begin
    if (i_mul_valid) begin
      o_wb_valid   = (i_mul_rnid != '0); // No write to x0
      o_wb_rnid    = i_mul_rnid;
      o_wb_data    = i_mul_data;
      o_done_valid = 1'b1;
      o_done_tag   = i_mul_tag;
    end else begin
      o_wb_valid   = i_alu_valid & (i_alu_rnid != '0);
      o_wb_rnid    = i_alu_rnid;
      o_wb_data    = i_alu_data;
      o_done_valid = i_alu_valid;
      o_done_tag   = i_alu_tag;
    end
  end

  // The pipe stall keeps both sources apart
  a_no_collision: assert final ((i_alu_valid & i_mul_valid) !== 1'b1)
    else $error("ALU and multiplier results collide at the writeback port");

endmodule

// File: mul_unit/mul_unit.sv
/* Iterative multiplier
   Retires MUL_UNROLL multiplier bits per cycle and returns the low word of the product */
`timescale 1ns/10ps

module mul_unit #(
  parameter int MUL_UNROLL = 8
) (
  input  logic            i_clk,
  input  logic            i_reset_n,
  input  logic            i_flush,
  input  logic            i_start,
  input  isa_pkg::xlen_t  i_rs1,
  input  isa_pkg::xlen_t  i_rs2,
  input  core_pkg::rnid_t i_rd_rnid,
  input  core_pkg::tag_t  i_tag,
  output logic            o_busy,
  output logic            o_res_valid,
  output isa_pkg::xlen_t  o_res,
  output core_pkg::rnid_t o_res_rnid,
  output core_pkg::tag_t  o_res_tag
);

  localparam int STEPS = isa_pkg::XLEN_W / MUL_UNROLL;
  localparam int CNT_W = $clog2(STEPS + 1);

  core_pkg::mul_state_t r_state;
  logic [CNT_W-1:0]     r_cnt;
  isa_pkg::xlen_t       r_mcand;
  isa_pkg::xlen_t       r_mplier;
  isa_pkg::xlen_t       r_acc;
  core_pkg::rnid_t      r_rnid;
  core_pkg::tag_t       r_tag;
  isa_pkg::xlen_t       w_partial;
  logic                 w_done;
  logic                 w_load;

  // Low word only, so signedness of the operands does not matter
  assign w_partial = r_mcand * isa_pkg::xlen_t'(r_mplier[MUL_UNROLL-1:0]);
  assign w_done    = (r_cnt == CNT_W'(STEPS));
  assign w_load    = i_start & (r_state == core_pkg::IDLE) & !i_flush;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= core_pkg::IDLE;
      r_cnt   <= '0;
    end else if (i_flush) begin
      r_state <= core_pkg::IDLE;
    end else begin
      case (r_state)
        core_pkg::IDLE: begin
          if (i_start) begin
            r_state <= core_pkg::RUN;
            r_cnt   <= '0;
          end
        end
        core_pkg::RUN: begin
          if (w_done) r_state <= core_pkg::IDLE;
          else r_cnt <= r_cnt + 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_mcand  <= i_rs1;
      r_mplier <= i_rs2;
      r_acc    <= '0;
      r_rnid   <= i_rd_rnid;
      r_tag    <= i_tag;
    end else if (r_state == core_pkg::RUN && !w_done) begin
      r_acc    <= r_acc + w_partial;
      r_mcand  <= r_mcand << MUL_UNROLL;
      r_mplier <= r_mplier >> MUL_UNROLL;
    end
  end

  assign o_busy      = (r_state == core_pkg::RUN); // Includes the result cycle
  assign o_res_valid = o_busy & w_done;
  assign o_res       = r_acc;
  assign o_res_rnid  = r_rnid;
  assign o_res_tag   = r_tag;

  a_no_start_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_start |-> !o_busy)
    else $error("multiply started while the multiplier is busy");

endmodule

// File: project.f
common/isa_pkg.sv
common/core_pkg.sv
hw/alu_decode.sv
hw/operand_fwd.sv
hw/alu_execute.sv
mul_unit/mul_unit.sv
hw/result_arbiter.sv
hw/alu_pipe.sv
+incdir+testbench
testbench/tb_alu_pipe.sv

// File: testbench/tb_alu_checks.svh
/* ALU pipe scoreboard checks
   Concurrent assertions on done tags, writeback values, read requests, latency and MUL stall */
`ifndef TB_ALU_CHECKS_SVH
`define TB_ALU_CHECKS_SVH

  // Every done belongs to a live tag
  a_done_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid |-> pending[o_done_tag])
    else flag_error($sformatf("done for tag %0d which is not in flight", o_done_tag));

  a_wb_value: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid && pending[o_done_tag] && exp_rd[o_done_tag] != '0 |->
      o_wb_valid && o_wb_rnid == exp_rd[o_done_tag] && o_wb_data == exp_data[o_done_tag])
    else flag_error($sformatf("tag %0d wb rnid %0d data %h, expected rnid %0d data %h",
      o_done_tag, o_wb_rnid, o_wb_data, exp_rd[o_done_tag], exp_data[o_done_tag]));

  a_no_wb_x0: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid && exp_rd[o_done_tag] == '0 |-> !o_wb_valid)
    else flag_error($sformatf("tag %0d wrote back to rename ID 0", o_done_tag));

  // EX1 read requests follow the issued source flags
  a_rf_read: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_rs1_rd_valid == rd_exp[0] && o_rs2_rd_valid == rd_exp[1] &&
      (!rd_exp[0] || o_rs1_rd_rnid == rd_id[0]) && (!rd_exp[1] || o_rs2_rd_rnid == rd_id[1]))
    else flag_error($sformatf("read request rs1 %b/%0d rs2 %b/%0d, expected %b/%0d %b/%0d",
      o_rs1_rd_valid, o_rs1_rd_rnid, o_rs2_rd_valid, o_rs2_rd_rnid,
      rd_exp[0], rd_id[0], rd_exp[1], rd_id[1]));

  // ALU ops finish exactly 3 cycles after issue, in order
  a_alu_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    due_v[2] |-> o_done_valid && o_done_tag == due_tag[2])
    else flag_error($sformatf("tag %0d not done 3 cycles after issue", due_tag[2]));

  // Stall spans a multiply from the cycle after issue to its result
  a_mul_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_stall == mul_flag)
    else flag_error($sformatf("stall %b, expected %b for the multiply in flight",
      o_stall, mul_flag));

`endif

// File: testbench/tb_alu_pipe.sv
/* Testbench for the integer ALU pipe
   Register-file model, bypass driver, LFSR operands and a per-tag scoreboard */
`timescale 1ns/10ps

module tb_alu_pipe;

  localparam int NF = core_pkg::FWD_PORTS;
  localparam int RUN_CYCLES = 40 * 12 + 6 * 30 + 200; // ops x worst latency, settle, margin

  logic i_clk, i_reset_n, i_flush, i_issue_valid;
  logic i_rs1_used, i_rs2_used;
  isa_pkg::inst_t  i_issue_inst;
  isa_pkg::vaddr_t i_issue_pc;
  core_pkg::tag_t  i_issue_tag;
  core_pkg::rnid_t i_rs1_rnid, i_rs2_rnid, i_rd_rnid;
  logic o_rs1_rd_valid, o_rs2_rd_valid, o_stall, o_wb_valid, o_done_valid;
  core_pkg::rnid_t o_rs1_rd_rnid, o_rs2_rd_rnid, o_wb_rnid;
  isa_pkg::xlen_t  o_wb_data;
  core_pkg::tag_t  o_done_tag;
  logic [NF-1:0]   i_fwd_valid;
  core_pkg::rnid_t i_fwd_rnid [NF];
  isa_pkg::xlen_t  i_fwd_data [NF];

  isa_pkg::xlen_t  rf [64];
  isa_pkg::xlen_t  exp_data [32];
  core_pkg::rnid_t exp_rd [32];
  logic [31:0]     pending;
  logic [2:0]      due_v;
  core_pkg::tag_t  due_tag [3];
  logic [1:0]      rd_exp;
  core_pkg::rnid_t rd_id [2];
  logic            issue_mul, mul_flag;
  core_pkg::tag_t  mul_tag, next_tag;
  logic [31:0]     lfsr;
  int              errors, tests, cycles;

  alu_pipe u_alu_pipe (.*, .i_rs1_rd_data(rf[o_rs1_rd_rnid]), .i_rs2_rd_data(rf[o_rs2_rd_rnid]));

  always #10 i_clk = ~i_clk;

  task automatic flag_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  `include "tb_alu_checks.svh"

  // ------------------------------------------------------------
  // Models and scoreboard bookkeeping
  // ------------------------------------------------------------
  always @(posedge i_clk) begin
    cycles++;
    if (o_wb_valid) rf[o_wb_rnid] <= o_wb_data;
    if (o_done_valid) pending[o_done_tag] <= 1'b0;
    if (o_done_valid && o_done_tag == mul_tag) mul_flag <= 1'b0;
    due_v   <= {due_v[1:0], i_issue_valid & !issue_mul} & {3{!i_flush}};
    due_tag <= '{i_issue_tag, due_tag[0], due_tag[1]};
    rd_exp  <= {i_rs2_used, i_rs1_used} & {2{i_issue_valid & !i_flush}};
    rd_id   <= '{i_rs1_rnid, i_rs2_rnid};
    if (i_flush) begin
      pending  <= '0;
      mul_flag <= 1'b0;
    end
    if (cycles >= RUN_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // RV32I result by funct3, alt selects SUB / SRA
  function automatic logic [31:0] rv_result(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic issue_op(input logic [31:0] inst, input logic [31:0] pc,
                          input core_pkg::rnid_t rs1, input core_pkg::rnid_t rs2,
                          input logic u1, input logic u2, input core_pkg::rnid_t rd,
                          input logic [31:0] exp, input logic is_mul);
    while (o_stall) @(posedge i_clk) #1;
    i_issue_valid = 1'b1;
    i_issue_inst  = inst;
    i_issue_pc    = pc;
    i_issue_tag   = next_tag;
    i_rs1_rnid    = rs1;
    i_rs2_rnid    = rs2;
    i_rs1_used    = u1;
    i_rs2_used    = u2;
    i_rd_rnid     = rd;
    issue_mul     = is_mul;
    exp_data[next_tag] = exp;
    exp_rd[next_tag]   = rd;
    pending[next_tag]  = 1'b1;
    @(posedge i_clk) #1;
    i_issue_valid = 1'b0;
    issue_mul     = 1'b0;
    if (is_mul) begin
      mul_flag = 1'b1;
      mul_tag  = next_tag;
    end
    next_tag++;
  endtask

  task automatic rr_op(input logic [6:0] f7, input logic [2:0] f3, input core_pkg::rnid_t rd);
    core_pkg::rnid_t rs1, rs2;
    logic [31:0] exp;
    rs1 = 6'(rand_bits(5)) + 6'd1;
    rs2 = 6'(rand_bits(5)) + 6'd1;
    if (f7 == 7'h01) exp = rf[rs1] * rf[rs2];
    else exp = rv_result(f3, f7[5], rf[rs1], rf[rs2]);
    issue_op({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011}, 32'h0, rs1, rs2, 1, 1, rd,
             exp, f7 == 7'h01);
  endtask

  task automatic imm_op(input logic [2:0] f3, input logic alt);
    core_pkg::rnid_t rs1, rd;
    logic [11:0] imm;
    logic [31:0] b;
    rs1 = 6'(rand_bits(5)) + 6'd1;
    rd  = 6'd48 + 6'(rand_bits(4));
    imm = 12'(rand_bits(12));
    if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, alt, 5'b0, imm[4:0]};
    b = (f3 == 3'b001 || f3 == 3'b101) ? {27'b0, imm[4:0]} : {{20{imm[11]}}, imm};
    issue_op({imm, rs1[4:0], f3, rd[4:0], 7'b0010011}, 32'h0, rs1, 6'd0, 1, 0, rd,
             rv_result(f3, alt & (f3 == 3'b101), rf[rs1], b), 0);
  endtask

  // Bypass slot s carries rnid/data for one cycle starting now
  task automatic drive_fwd(input int s, input core_pkg::rnid_t id, input logic [31:0] d);
    i_fwd_valid[s] = 1'b1;
    i_fwd_rnid[s]  = id;
    i_fwd_data[s]  = d;
  endtask

  task automatic wait_idle();
    while (pending != '0) @(posedge i_clk) #1;
    repeat (2) @(posedge i_clk) #1;
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    int e;
    logic [31:0] d1, d2, u;
    i_clk = 0;
    i_reset_n = 0;
    i_flush = 0;
    i_issue_valid = 0;
    i_issue_inst = '0;
    i_issue_pc = '0;
    i_issue_tag = '0;
    i_rs1_rnid = '0;
    i_rs2_rnid = '0;
    i_rd_rnid = '0;
    i_rs1_used = 0;
    i_rs2_used = 0;
    i_fwd_valid = '0;
    i_fwd_rnid = '{default: '0};
    i_fwd_data = '{default: '0};
    pending = '0;
    due_v = '0;
    due_tag = '{default: '0};
    rd_exp = '0;
    rd_id = '{default: '0};
    issue_mul = 0;
    mul_flag = 0;
    mul_tag = '1;
    next_tag = '0;
    errors = 0;
    tests = 0;
    cycles = 0;
    lfsr = 32'h316db96f;
    rf[0] = '0;
    for (int i = 1; i < 64; i++) rf[i] = rand_bits(32);
    repeat (4) @(posedge i_clk);
    #1 i_reset_n = 1;
    @(posedge i_clk) #1;

    e = errors; // Register-register
    for (int f = 0; f < 8; f++) rr_op(7'h00, 3'(f), 6'd48 + 6'(rand_bits(4)));
    rr_op(7'h20, 3'b000, 6'd50);
    rr_op(7'h20, 3'b101, 6'd51);
    rr_op(7'h00, 3'b000, 6'd0);
    wait_idle();
    end_test("register ops", e);

    e = errors; // Immediates and U-type
    for (int f = 0; f < 8; f++) imm_op(3'(f), 1'b0);
    imm_op(3'b101, 1'b1);
    u = rand_bits(32) & 32'hfffff000;
    issue_op({u[31:12], 5'd3, 7'b0110111}, 32'h0, 0, 0, 0, 0, 6'd52, u, 0);
    d1 = rand_bits(32);
    issue_op({u[31:12], 5'd3, 7'b0010111}, d1, 0, 0, 0, 0, 6'd53, d1 + u, 0);
    wait_idle();
    end_test("immediate ops", e);

    e = errors; // EX1 bypass, EX2 override, rename ID 0
    d1 = rand_bits(32);
    issue_op({7'h00, 5'd2, 5'd1, 3'b000, 5'd4, 7'b0110011}, 0, 6'd5, 6'd6, 1, 1, 6'd54,
             d1 + rf[6], 0);
    drive_fwd(0, 6'd5, d1);
    @(posedge i_clk) #1 i_fwd_valid = '0;
    d1 = rand_bits(32);
    d2 = rand_bits(32);
    issue_op({7'h00, 5'd2, 5'd1, 3'b100, 5'd4, 7'b0110011}, 0, 6'd7, 6'd8, 1, 1, 6'd55,
             rf[7] ^ d2, 0);
    drive_fwd(0, 6'd8, d1);
    @(posedge i_clk) #1 drive_fwd(1, 6'd8, d2);
    i_fwd_valid[0] = 1'b0;
    @(posedge i_clk) #1 i_fwd_valid = '0;
    issue_op({7'h00, 5'd2, 5'd0, 3'b000, 5'd4, 7'b0110011}, 0, 6'd0, 6'd9, 1, 1, 6'd56,
             rf[9], 0);
    drive_fwd(0, 6'd0, rand_bits(32));
    repeat (2) @(posedge i_clk) #1;
    i_fwd_valid = '0;
    wait_idle();
    end_test("bypass", e);

    e = errors; // Multiply with stall
    for (int i = 0; i < 3; i++) rr_op(7'h01, 3'b000, 6'd57 + 6'(i));
    rr_op(7'h00, 3'b000, 6'd60);
    wait_idle();
    end_test("multiply", e);

    e = errors; // Flush of ALU ops and of a running multiply
    rr_op(7'h00, 3'b000, 6'd61);
    rr_op(7'h00, 3'b110, 6'd62);
    i_flush = 1'b1;
    @(posedge i_clk) #1 i_flush = 1'b0;
    rr_op(7'h01, 3'b000, 6'd63);
    repeat (3) @(posedge i_clk) #1;
    i_flush = 1'b1;
    @(posedge i_clk) #1 i_flush = 1'b0;
    repeat (12) @(posedge i_clk) #1;
    end_test("flush", e);

    e = errors; // Back-to-back, latency checked per op
    for (int i = 0; i < 8; i++) rr_op(7'h00, i[0] ? 3'b100 : 3'b000, 6'd48 + 6'(i));
    wait_idle();
    end_test("back to back", e);

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
